// ==== common/fetch_cfg.svh ====
// width, predictor table and fetch queue configuration macros
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// address and instruction word width
`define FETCH_XLEN 32

// branch history table entries, power of two
`define FETCH_BHT_ENTRIES 64

// fetch queue entries, at least 3
`define FETCH_QUEUE_DEPTH 4

// low address bits below one instruction
`define FETCH_ALIGN_BITS 2

`endif

// ==== common/fetch_pkg.sv ====
// fetch types for control-flow class, instruction word views and queue entry
`include "fetch_cfg.svh"

package fetch_pkg;

  // predicted control flow carried with each queued instruction
  typedef enum logic [1:0] {
    cf_none,
    cf_branch,
    cf_jump
  } cf_e;

  // B format, the offset is scattered over the word
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  // J format as used by jal
  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // one fetched word, read as branch or as jump by the pre-decoder
  typedef union packed {
    logic [31:0] raw;
    b_fmt_t      b_view;
    j_fmt_t      j_view;
  } instr_u;

  // entry handed to decode
  typedef struct packed {
    logic [`FETCH_XLEN-1:0] pc;
    logic [31:0]            instr;
    cf_e                    cf;
    // predicted next pc of this instruction
    logic [`FETCH_XLEN-1:0] target;
  } fetch_entry_t;

endpackage

// ==== common/bht_if.sv ====
// lookup and update channel between the PC stage and the branch history table
`timescale 1ns/100ps
`include "fetch_cfg.svh"

interface bht_if;

  // lookup of the response-stage instruction
  logic [`FETCH_XLEN-1:0] lookup_pc;
  logic                   pred_valid;
  logic                   pred_taken;

  // training from resolved branches
  logic                   upd_valid;
  logic [`FETCH_XLEN-1:0] upd_pc;
  logic                   upd_taken;

  modport predictor (
    input  lookup_pc, upd_valid, upd_pc, upd_taken,
    output pred_valid, pred_taken
  );

  modport fetch (
    output lookup_pc, upd_valid, upd_pc, upd_taken,
    input  pred_valid, pred_taken
  );

endinterface

// ==== bpred/bht.sv ====
// direct-mapped branch history table of 2-bit saturating counters
`timescale 1ns/100ps
`include "fetch_cfg.svh"

module bht (
  input logic      clk_i,
  input logic      rst_ni,
  bht_if.predictor bht_bus
);

  localparam int unsigned entries = `FETCH_BHT_ENTRIES;
  localparam int unsigned idx_w   = $clog2(entries);
  localparam int unsigned align   = `FETCH_ALIGN_BITS;

  // entry state, counter msb is the prediction
  logic [entries-1:0] valid_q;
  logic [1:0]         cnt_q [entries];

  logic [idx_w-1:0] lookup_idx;
  logic [idx_w-1:0] upd_idx;
  logic [1:0]       upd_cnt;

  // index with the bits right above the instruction alignment
  assign lookup_idx = bht_bus.lookup_pc[align +: idx_w];
  assign upd_idx    = bht_bus.upd_pc[align +: idx_w];

  // ------------------------------------------------------------
  // lookup
  // ------------------------------------------------------------
  assign bht_bus.pred_valid = valid_q[lookup_idx];
  assign bht_bus.pred_taken = cnt_q[lookup_idx][1];

  // ------------------------------------------------------------
  // update
  // ------------------------------------------------------------
  always_comb begin
    upd_cnt = cnt_q[upd_idx];
    if (!valid_q[upd_idx]) begin
      // first sighting starts weak in the resolved direction
      upd_cnt = bht_bus.upd_taken ? 2'b10 : 2'b01;
    end else if (bht_bus.upd_taken) begin
      if (cnt_q[upd_idx] != 2'b11) begin
        upd_cnt = cnt_q[upd_idx] + 2'd1;
      end
    end else if (cnt_q[upd_idx] != 2'b00) begin
      upd_cnt = cnt_q[upd_idx] - 2'd1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (bht_bus.upd_valid) begin
      valid_q[upd_idx] <= 1'b1;
    end
  end

  // counters are only read once their valid bit is set
  always_ff @(posedge clk_i) begin
    if (bht_bus.upd_valid) begin
      cnt_q[upd_idx] <= upd_cnt;
    end
  end

endmodule

// ==== logic/instr_scan.sv ====
// pre-decoder that classifies one instruction and extracts its branch or jump offset
`timescale 1ns/100ps
`include "fetch_cfg.svh"

module instr_scan (
  input  fetch_pkg::instr_u      instr_i,
  output fetch_pkg::cf_e         cf_o,
  output logic [`FETCH_XLEN-1:0] imm_o
);

  localparam int unsigned xlen       = `FETCH_XLEN;
  localparam logic [6:0]  opc_branch = 7'b1100011;
  localparam logic [6:0]  opc_jal    = 7'b1101111;

  logic [xlen-1:0] b_imm;
  logic [xlen-1:0] j_imm;

  // B offset, 13 bits with implied zero lsb
  assign b_imm = {
    {(xlen - 12){instr_i.b_view.imm12}},
    instr_i.b_view.imm11,
    instr_i.b_view.imm10_5,
    instr_i.b_view.imm4_1,
    1'b0
  };

  // J offset, 21 bits with implied zero lsb
  assign j_imm = {
    {(xlen - 20){instr_i.j_view.imm20}},
    instr_i.j_view.imm19_12,
    instr_i.j_view.imm11,
    instr_i.j_view.imm10_1,
    1'b0
  };

  // jalr is not predicted and falls into the plain class
  always_comb begin
    cf_o  = fetch_pkg::cf_none;
    imm_o = '0;
    if (instr_i.b_view.opcode == opc_branch) begin
      cf_o  = fetch_pkg::cf_branch;
      imm_o = b_imm;
    end else if (instr_i.j_view.opcode == opc_jal) begin
      cf_o  = fetch_pkg::cf_jump;
      imm_o = j_imm;
    end
  end

endmodule

// ==== logic/instr_queue.sv ====
// circular fetch queue with valid/ready decode port and free-space count
`timescale 1ns/100ps
`include "fetch_cfg.svh"

module instr_queue (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   flush_i,
  input  logic                                   push_i,
  input  fetch_pkg::fetch_entry_t                entry_i,
  input  logic                                   fetch_ready_i,
  output logic                                   fetch_valid_o,
  output fetch_pkg::fetch_entry_t                fetch_entry_o,
  output logic [$clog2(`FETCH_QUEUE_DEPTH+1)-1:0] free_o
);

  localparam int unsigned depth = `FETCH_QUEUE_DEPTH;
  localparam int unsigned ptr_w = $clog2(depth);
  localparam int unsigned cnt_w = $clog2(depth + 1);

  fetch_pkg::fetch_entry_t mem_q [depth];

  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic [cnt_w-1:0] count_q;
  logic             pop;

  // wrap also for depths that are not a power of two
  function automatic logic [ptr_w-1:0] ptr_next(input logic [ptr_w-1:0] ptr);
    return (ptr == ptr_w'(depth - 1)) ? '0 : ptr + ptr_w'(1);
  endfunction

  // head of queue goes straight to decode
  assign fetch_valid_o = (count_q != '0);
  assign fetch_entry_o = mem_q[rd_ptr_q];
  assign pop           = fetch_valid_o & fetch_ready_i;

  // the request side never pushes into a full queue
  assign free_o = cnt_w'(depth) - count_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      // push and pop together leave the count as is
      if (push_i && !pop) begin
        count_q <= count_q + cnt_w'(1);
      end else if (!push_i && pop) begin
        count_q <= count_q - cnt_w'(1);
      end
    end
  end

  // entry storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= entry_i;
    end
  end

endmodule

// ==== logic/pc_gen.sv ====
// next-PC register, redirect priority mux, cache response stage and taken prediction
`timescale 1ns/100ps
`include "fetch_cfg.svh"

module pc_gen (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic [`FETCH_XLEN-1:0]                 boot_addr_i,
  // redirects from the back end
  input  logic                                   flush_i,
  input  logic                                   halt_i,
  input  logic                                   set_pc_commit_i,
  input  logic [`FETCH_XLEN-1:0]                 pc_commit_i,
  input  logic                                   ex_valid_i,
  input  logic [`FETCH_XLEN-1:0]                 trap_vector_i,
  input  logic                                   eret_i,
  input  logic [`FETCH_XLEN-1:0]                 epc_i,
  // resolved branch from execute
  input  logic                                   resolve_valid_i,
  input  logic [`FETCH_XLEN-1:0]                 resolve_pc_i,
  input  logic                                   resolve_is_branch_i,
  input  logic                                   resolve_taken_i,
  input  logic                                   resolve_mispredict_i,
  input  logic [`FETCH_XLEN-1:0]                 resolve_target_i,
  // instruction cache
  input  logic                                   cache_ready_i,
  input  logic                                   rsp_valid_i,
  input  logic [31:0]                            rsp_data_i,
  input  logic [`FETCH_XLEN-1:0]                 rsp_vaddr_i,
  output logic                                   req_o,
  output logic [`FETCH_XLEN-1:0]                 vaddr_o,
  output logic                                   kill_o,
  // pre-decode of the response stage
  input  fetch_pkg::cf_e                         cf_i,
  input  logic [`FETCH_XLEN-1:0]                 imm_i,
  // queue room against requests still on their way
  input  logic [$clog2(`FETCH_QUEUE_DEPTH+1)-1:0] free_i,
  input  logic [$clog2(`FETCH_QUEUE_DEPTH+1)-1:0] outstanding_i,
  // response stage towards scan and queue
  output fetch_pkg::instr_u                      rsp_instr_o,
  output logic [`FETCH_XLEN-1:0]                 rsp_pc_o,
  output logic                                   push_o,
  output fetch_pkg::cf_e                         cf_o,
  output logic [`FETCH_XLEN-1:0]                 target_o,
  bht_if.fetch                                   bht_bus
);

  localparam int unsigned xlen  = `FETCH_XLEN;
  localparam int unsigned align = `FETCH_ALIGN_BITS;
  localparam int unsigned hi_w  = xlen - align;

  logic              npc_rst_load_q;
  logic [xlen-1:0]   npc_q;
  logic [xlen-1:0]   npc_d;
  logic [xlen-1:0]   fetch_addr;
  logic              rsp_valid_q;
  fetch_pkg::instr_u rsp_instr_q;
  logic [xlen-1:0]   rsp_pc_q;
  logic              bp_taken;
  logic              redirect;

  // ------------------------------------------------------------
  // prediction on the response stage
  // ------------------------------------------------------------
  assign bht_bus.lookup_pc = rsp_pc_q;

  always_comb begin
    unique case (cf_i)
      fetch_pkg::cf_jump:   bp_taken = rsp_valid_q;
      // trained entry wins, else backward taken
      fetch_pkg::cf_branch: bp_taken = rsp_valid_q &
                                       (bht_bus.pred_valid ? bht_bus.pred_taken : imm_i[xlen-1]);
      default:              bp_taken = 1'b0;
    endcase
  end

  assign cf_o     = bp_taken ? cf_i : fetch_pkg::cf_none;
  assign target_o = bp_taken ? rsp_pc_q + imm_i : rsp_pc_q + xlen'(4);

  // a taken branch still enters the queue, a flush drops it
  assign push_o      = rsp_valid_q & ~flush_i;
  assign rsp_instr_o = rsp_instr_q;
  assign rsp_pc_o    = rsp_pc_q;

  // train on every resolved conditional branch
  assign bht_bus.upd_valid = resolve_valid_i & resolve_is_branch_i;
  assign bht_bus.upd_pc    = resolve_pc_i;
  assign bht_bus.upd_taken = resolve_taken_i;

  // ------------------------------------------------------------
  // cache request and kill
  // ------------------------------------------------------------
  assign redirect = (resolve_valid_i & resolve_mispredict_i) | eret_i | ex_valid_i |
                    set_pc_commit_i;
  assign kill_o   = redirect | flush_i | bp_taken;

  // boot address is taken from the port once reset is released
  assign fetch_addr = npc_rst_load_q ? boot_addr_i : npc_q;
  assign vaddr_o    = fetch_addr;

  // only request when a queue slot is left for the answer
  assign req_o = ~npc_rst_load_q & ~kill_o & (free_i > outstanding_i);

  // next pc, later assignments take precedence
  always_comb begin
    npc_d = fetch_addr;
    if (req_o && cache_ready_i) begin
      npc_d = {fetch_addr[xlen-1:align] + hi_w'(1), {align{1'b0}}};
    end
    if (bp_taken) begin
      npc_d = target_o;
    end
    if (resolve_valid_i && resolve_mispredict_i) begin
      npc_d = resolve_target_i;
    end
    if (eret_i) begin
      npc_d = epc_i;
    end
    if (ex_valid_i) begin
      npc_d = trap_vector_i;
    end
    // halted commit refetches the instruction itself
    if (set_pc_commit_i) begin
      npc_d = pc_commit_i + (halt_i ? '0 : xlen'(4));
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      npc_rst_load_q <= 1'b1;
      npc_q          <= '0;
      rsp_valid_q    <= 1'b0;
    end else begin
      npc_rst_load_q <= 1'b0;
      npc_q          <= npc_d;
      // answers arriving with a kill belong to the discarded path
      rsp_valid_q    <= rsp_valid_i & ~kill_o;
    end
  end

  // response payload
  always_ff @(posedge clk_i) begin
    if (rsp_valid_i) begin
      rsp_instr_q <= rsp_data_i;
      rsp_pc_q    <= rsp_vaddr_i;
    end
  end

endmodule

// ==== logic/fetch_frontend.sv ====
// fetch front end top with cache port, predictor, pre-decoder and decode queue
`timescale 1ns/100ps
`include "fetch_cfg.svh"

module fetch_frontend (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic [`FETCH_XLEN-1:0]  boot_addr_i,
  // back-end control
  input  logic                    flush_i,
  input  logic                    halt_i,
  input  logic                    set_pc_commit_i,
  input  logic [`FETCH_XLEN-1:0]  pc_commit_i,
  input  logic                    ex_valid_i,
  input  logic [`FETCH_XLEN-1:0]  trap_vector_i,
  input  logic                    eret_i,
  input  logic [`FETCH_XLEN-1:0]  epc_i,
  // branch resolution
  input  logic                    resolve_valid_i,
  input  logic [`FETCH_XLEN-1:0]  resolve_pc_i,
  input  logic                    resolve_is_branch_i,
  input  logic                    resolve_taken_i,
  input  logic                    resolve_mispredict_i,
  input  logic [`FETCH_XLEN-1:0]  resolve_target_i,
  // instruction cache
  input  logic                    cache_ready_i,
  output logic                    req_o,
  output logic [`FETCH_XLEN-1:0]  vaddr_o,
  output logic                    kill_o,
  input  logic                    rsp_valid_i,
  input  logic [31:0]             rsp_data_i,
  input  logic [`FETCH_XLEN-1:0]  rsp_vaddr_i,
  // decode
  output logic                    fetch_valid_o,
  output fetch_pkg::fetch_entry_t fetch_entry_o,
  input  logic                    fetch_ready_i
);

  localparam int unsigned xlen  = `FETCH_XLEN;
  localparam int unsigned cnt_w = $clog2(`FETCH_QUEUE_DEPTH + 1);

  bht_if bht_bus ();

  fetch_pkg::instr_u       rsp_instr;
  logic [xlen-1:0]         rsp_pc;
  fetch_pkg::cf_e          scan_cf;
  logic [xlen-1:0]         scan_imm;
  fetch_pkg::cf_e          entry_cf;
  logic [xlen-1:0]         entry_target;
  logic                    push;
  fetch_pkg::fetch_entry_t entry;
  logic [cnt_w-1:0]        free;
  logic [cnt_w-1:0]        outstanding_q;
  logic [cnt_w-1:0]        outstanding_d;
  logic                    accept;

  // ------------------------------------------------------------
  // outstanding requests
  // ------------------------------------------------------------
  // counts from acceptance until the push, so the response stage is covered
  assign accept = req_o & cache_ready_i;

  always_comb begin
    outstanding_d = outstanding_q;
    if (kill_o) begin
      // cache drops all in flight, the stage entry leaves on this edge
      outstanding_d = '0;
    end else if (accept && !push) begin
      outstanding_d = outstanding_q + cnt_w'(1);
    end else if (!accept && push) begin
      outstanding_d = outstanding_q - cnt_w'(1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding_q <= '0;
    end else begin
      outstanding_q <= outstanding_d;
    end
  end

  // ------------------------------------------------------------
  // blocks
  // ------------------------------------------------------------
  pc_gen pc_gen_i (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .boot_addr_i         (boot_addr_i),
    .flush_i             (flush_i),
    .halt_i              (halt_i),
    .set_pc_commit_i     (set_pc_commit_i),
    .pc_commit_i         (pc_commit_i),
    .ex_valid_i          (ex_valid_i),
    .trap_vector_i       (trap_vector_i),
    .eret_i              (eret_i),
    .epc_i               (epc_i),
    .resolve_valid_i     (resolve_valid_i),
    .resolve_pc_i        (resolve_pc_i),
    .resolve_is_branch_i (resolve_is_branch_i),
    .resolve_taken_i     (resolve_taken_i),
    .resolve_mispredict_i(resolve_mispredict_i),
    .resolve_target_i    (resolve_target_i),
    .cache_ready_i       (cache_ready_i),
    .rsp_valid_i         (rsp_valid_i),
    .rsp_data_i          (rsp_data_i),
    .rsp_vaddr_i         (rsp_vaddr_i),
    .req_o               (req_o),
    .vaddr_o             (vaddr_o),
    .kill_o              (kill_o),
    .cf_i                (scan_cf),
    .imm_i               (scan_imm),
    .free_i              (free),
    .outstanding_i       (outstanding_q),
    .rsp_instr_o         (rsp_instr),
    .rsp_pc_o            (rsp_pc),
    .push_o              (push),
    .cf_o                (entry_cf),
    .target_o            (entry_target),
    .bht_bus             (bht_bus.fetch)
  );

  bht bht_i (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .bht_bus(bht_bus.predictor)
  );

  // decodes the registered response word
  instr_scan instr_scan_i (
    .instr_i(rsp_instr),
    .cf_o   (scan_cf),
    .imm_o  (scan_imm)
  );

  assign entry = '{
    pc:     rsp_pc,
    instr:  rsp_instr.raw,
    cf:     entry_cf,
    target: entry_target
  };

  instr_queue instr_queue_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .push_i       (push),
    .entry_i      (entry),
    .fetch_ready_i(fetch_ready_i),
    .fetch_valid_o(fetch_valid_o),
    .fetch_entry_o(fetch_entry_o),
    .free_o       (free)
  );

endmodule

// ==== dv/tb_fetch_frontend.sv ====
// directed testbench for the fetch front end with cache model, redirect stimulus and checks
`timescale 1ns/100ps

module tb_fetch_frontend;

  localparam logic [31:0] base_addr   = 32'h8000_0000;
  localparam logic [31:0] pred_base   = base_addr + 32'h100;
  localparam logic [31:0] jump_base   = base_addr + 32'h200;
  localparam logic [31:0] train_pc    = base_addr + 32'h304;
  localparam logic [31:0] tgt_mis     = base_addr + 32'h040;
  localparam logic [31:0] tgt_eret    = base_addr + 32'h080;
  localparam logic [31:0] tgt_trap    = base_addr + 32'h0c0;
  localparam logic [31:0] tgt_commit  = base_addr + 32'h3c0;
  localparam int          num_tests   = 6;
  localparam int          cycle_limit = num_tests * 400;

  logic                    clk_i                = 1'b0;
  logic                    rst_ni               = 1'b0;
  logic [31:0]             boot_addr_i          = base_addr;
  logic                    flush_i              = 1'b0;
  logic                    halt_i               = 1'b0;
  logic                    set_pc_commit_i      = 1'b0;
  logic [31:0]             pc_commit_i          = '0;
  logic                    ex_valid_i           = 1'b0;
  logic [31:0]             trap_vector_i        = '0;
  logic                    eret_i               = 1'b0;
  logic [31:0]             epc_i                = '0;
  logic                    resolve_valid_i      = 1'b0;
  logic [31:0]             resolve_pc_i         = '0;
  logic                    resolve_is_branch_i  = 1'b0;
  logic                    resolve_taken_i      = 1'b0;
  logic                    resolve_mispredict_i = 1'b0;
  logic [31:0]             resolve_target_i     = '0;
  logic                    cache_ready_i        = 1'b1;
  logic                    rsp_valid_i          = 1'b0;
  logic [31:0]             rsp_data_i           = '0;
  logic [31:0]             rsp_vaddr_i          = '0;
  logic                    fetch_ready_i        = 1'b0;
  logic                    req_o;
  logic [31:0]             vaddr_o;
  logic                    kill_o;
  logic                    fetch_valid_o;
  fetch_pkg::fetch_entry_t fetch_entry_o;

  // instruction memory, 1 KiB window above base_addr
  logic [31:0]             mem [256];
  int                      cycle_cnt = 0;
  int                      check_cnt = 0;
  int                      error_cnt = 0;
  // answers still owed by the cache, in request order
  logic [31:0]             pend_addr [$];
  int                      pend_due [$];
  fetch_pkg::fetch_entry_t exp_q [$];
  fetch_pkg::fetch_entry_t got_q [$];

  fetch_frontend fetch_frontend_i (.*);

  always #10 clk_i = ~clk_i;

  // ------------------------------------------------------------
  // cache model and run limit
  // ------------------------------------------------------------
  always @(posedge clk_i) begin
    if (kill_o) begin
      // everything in flight belongs to the old path
      pend_addr.delete();
      pend_due.delete();
      rsp_valid_i <= 1'b0;
    end else begin
      if (pend_addr.size() != 0 && pend_due[0] <= cycle_cnt) begin
        rsp_valid_i <= 1'b1;
        rsp_vaddr_i <= pend_addr[0];
        rsp_data_i  <= mem_word(pend_addr[0]);
        pend_addr.delete(0);
        pend_due.delete(0);
      end else begin
        rsp_valid_i <= 1'b0;
      end
      if (req_o && cache_ready_i) begin
        pend_addr.push_back(vaddr_o);
        pend_due.push_back(cycle_cnt + $urandom_range(1, 3));
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout, tests did not finish within %0d cycles", cycle_limit);
      $display("summary: %0d checks, %0d errors", check_cnt, error_cnt);
      $display("Errors found");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // memory contents and expected entries
  // ------------------------------------------------------------
  // addi with an immediate taken from the whole address
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return {addr[31:7] ^ addr[24:0], 7'h13};
  endfunction

  // beq x1, x2 with a byte offset
  function automatic logic [31:0] branch_word(input int off);
    logic [31:0] o;
    o = off;
    return {o[12], o[10:5], 5'd2, 5'd1, 3'b000, o[4:1], o[11], 7'b1100011};
  endfunction

  // jal x1 with a byte offset
  function automatic logic [31:0] jal_word(input int off);
    logic [31:0] o;
    o = off;
    return {o[20], o[10:1], o[11], o[19:12], 5'd1, 7'b1101111};
  endfunction

  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return mem[addr[9:2]];
  endfunction

  task automatic put_word(input logic [31:0] addr, input logic [31:0] word);
    mem[addr[9:2]] = word;
  endtask

  function automatic fetch_pkg::fetch_entry_t make_entry(input logic [31:0] pc,
                                                         input fetch_pkg::cf_e cf,
                                                         input logic [31:0] target);
    fetch_pkg::fetch_entry_t e;
    e.pc     = pc;
    e.instr  = mem_word(pc);
    e.cf     = cf;
    e.target = target;
    return e;
  endfunction

  task automatic build_seq(input logic [31:0] start, input int n);
    exp_q.delete();
    for (int k = 0; k < n; k++) begin
      exp_q.push_back(make_entry(start + 32'(4 * k), fetch_pkg::cf_none, start + 32'(4 * k + 4)));
    end
  endtask

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------
  task automatic check_entry(input string what, input fetch_pkg::fetch_entry_t got,
                             input fetch_pkg::fetch_entry_t exp);
    check_cnt++;
    if (got.pc !== exp.pc) begin
      error_cnt++;
      $display("mismatch fetch_entry_o.pc: %h, expected %h (%s)", got.pc, exp.pc, what);
    end
    if (got.instr !== exp.instr) begin
      error_cnt++;
      $display("mismatch fetch_entry_o.instr: %h, expected %h (%s)", got.instr, exp.instr, what);
    end
    if (got.cf !== exp.cf) begin
      error_cnt++;
      $display("mismatch fetch_entry_o.cf: %h, expected %h (%s)", got.cf, exp.cf, what);
    end
    if (got.target !== exp.target) begin
      error_cnt++;
      $display("mismatch fetch_entry_o.target: %h, expected %h (%s)", got.target, exp.target,
               what);
    end
  endtask

  task automatic check_addr(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_cnt++;
    if (got !== exp) begin
      error_cnt++;
      $display("mismatch %s: %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    check_cnt++;
    if (got !== exp) begin
      error_cnt++;
      $display("mismatch %s: %h, expected %h", name, got, exp);
    end
  endtask

  // ------------------------------------------------------------
  // stimulus helpers, each starts and ends right after a rising edge
  // ------------------------------------------------------------
  task automatic reset_dut();
    rst_ni <= 1'b0;
    repeat (10) @(posedge clk_i);
    check_flag("req_o", req_o, 1'b0);
    check_flag("kill_o", kill_o, 1'b0);
    check_flag("fetch_valid_o", fetch_valid_o, 1'b0);
    rst_ni <= 1'b1;
    // boot request goes out on the first clock after release
    repeat (2) @(posedge clk_i);
    check_flag("req_o", req_o, 1'b1);
    check_addr("vaddr_o", vaddr_o, base_addr);
  endtask

  // one cycle of flush together with the chosen redirect sources
  task automatic drive_redirect(input bit mis, input bit eret, input bit ex, input bit commit,
                                input bit halt, input logic [31:0] commit_pc);
    flush_i              <= 1'b1;
    resolve_valid_i      <= mis;
    resolve_mispredict_i <= mis;
    resolve_target_i     <= tgt_mis;
    eret_i               <= eret;
    epc_i                <= tgt_eret;
    ex_valid_i           <= ex;
    trap_vector_i        <= tgt_trap;
    set_pc_commit_i      <= commit;
    halt_i               <= halt;
    pc_commit_i          <= commit_pc;
    @(posedge clk_i);
    flush_i              <= 1'b0;
    resolve_valid_i      <= 1'b0;
    resolve_mispredict_i <= 1'b0;
    eret_i               <= 1'b0;
    ex_valid_i           <= 1'b0;
    set_pc_commit_i      <= 1'b0;
    halt_i               <= 1'b0;
  endtask

  // commit of the word before addr restarts fetch at addr
  task automatic restart_at(input logic [31:0] addr);
    drive_redirect(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, addr - 32'd4);
  endtask

  task automatic resolve_branch(input logic [31:0] pc, input bit taken);
    resolve_valid_i     <= 1'b1;
    resolve_is_branch_i <= 1'b1;
    resolve_taken_i     <= taken;
    resolve_pc_i        <= pc;
    @(posedge clk_i);
    resolve_valid_i     <= 1'b0;
    resolve_is_branch_i <= 1'b0;
    resolve_taken_i     <= 1'b0;
  endtask

  // take n entries from decode port, optionally with random ready
  task automatic collect(input int n, input bit random_ready);
    got_q.delete();
    fetch_ready_i <= 1'b1;
    while (got_q.size() < n) begin
      @(posedge clk_i);
      if (fetch_valid_o && fetch_ready_i) begin
        got_q.push_back(fetch_entry_o);
      end
      if (got_q.size() >= n) begin
        fetch_ready_i <= 1'b0;
      end else if (random_ready) begin
        fetch_ready_i <= 1'($urandom);
      end
    end
  endtask

  task automatic expect_seq(input string what, input bit random_ready);
    collect(exp_q.size(), random_ready);
    foreach (exp_q[i]) begin
      check_entry(what, got_q[i], exp_q[i]);
    end
  endtask

  // ------------------------------------------------------------
  // tests
  // ------------------------------------------------------------
  task automatic seq_fetch();
    build_seq(base_addr, 12);
    expect_seq("sequential fetch", 1'b0);
  endtask

  // loop of five words, forward branch falls through, backward one returns
  task automatic static_pred();
    restart_at(pred_base);
    build_seq(pred_base, 4);
    exp_q.push_back(make_entry(pred_base + 32'd16, fetch_pkg::cf_branch, pred_base));
    exp_q.push_back(make_entry(pred_base, fetch_pkg::cf_none, pred_base + 32'd4));
    exp_q.push_back(make_entry(pred_base + 32'd4, fetch_pkg::cf_none, pred_base + 32'd8));
    exp_q.push_back(make_entry(pred_base + 32'd8, fetch_pkg::cf_none, pred_base + 32'd12));
    expect_seq("static prediction", 1'b0);
  endtask

  task automatic jump_follow();
    restart_at(jump_base);
    exp_q.delete();
    exp_q.push_back(make_entry(jump_base, fetch_pkg::cf_none, jump_base + 32'd4));
    exp_q.push_back(make_entry(jump_base + 32'd4, fetch_pkg::cf_jump, jump_base + 32'd16));
    exp_q.push_back(make_entry(jump_base + 32'd16, fetch_pkg::cf_none, jump_base + 32'd20));
    exp_q.push_back(make_entry(jump_base + 32'd20, fetch_pkg::cf_jump, jump_base));
    exp_q.push_back(make_entry(jump_base, fetch_pkg::cf_none, jump_base + 32'd4));
    exp_q.push_back(make_entry(jump_base + 32'd4, fetch_pkg::cf_jump, jump_base + 32'd16));
    expect_seq("jal", 1'b0);
  endtask

  // forward branch is not taken until one taken resolve trains it
  task automatic bht_training();
    restart_at(train_pc);
    build_seq(train_pc, 2);
    expect_seq("untrained branch", 1'b0);
    resolve_branch(train_pc, 1'b1);
    restart_at(train_pc);
    exp_q.delete();
    exp_q.push_back(make_entry(train_pc, fetch_pkg::cf_branch, train_pc + 32'd12));
    exp_q.push_back(make_entry(train_pc + 32'd12, fetch_pkg::cf_none, train_pc + 32'd16));
    expect_seq("trained branch", 1'b0);
  endtask

  task automatic priority_case(input bit mis, input bit eret, input bit ex, input bit commit,
                               input bit halt, input logic [31:0] exp_pc);
    drive_redirect(mis, eret, ex, commit, halt, tgt_commit);
    collect(2, 1'b0);
    check_addr("fetch_entry_o.pc", got_q[0].pc, exp_pc);
    check_entry("after redirect", got_q[1],
                make_entry(exp_pc + 32'd4, fetch_pkg::cf_none, exp_pc + 32'd8));
  endtask

  task automatic redirect_priority();
    priority_case(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, tgt_mis);
    priority_case(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, tgt_eret);
    priority_case(1'b1, 1'b1, 1'b1, 1'b0, 1'b0, tgt_trap);
    // halted commit points at the committed word itself
    priority_case(1'b1, 1'b1, 1'b1, 1'b1, 1'b1, tgt_commit);
  endtask

  task automatic back_pressure();
    restart_at(base_addr);
    build_seq(base_addr, 12);
    expect_seq("back-pressure", 1'b1);
  endtask

  initial begin
    void'($urandom(32'ha0f91c61));
    for (int i = 0; i < 256; i++) begin
      mem[i] = fill_word(base_addr + 32'(4 * i));
    end
    put_word(pred_base + 32'd8, branch_word(16));
    put_word(pred_base + 32'd16, branch_word(-16));
    put_word(jump_base + 32'd4, jal_word(12));
    put_word(jump_base + 32'd20, jal_word(-20));
    put_word(train_pc, branch_word(12));

    reset_dut();
    seq_fetch();
    static_pred();
    jump_follow();
    bht_training();
    redirect_priority();
    back_pressure();

    $display("summary: %0d checks, %0d errors", check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+common
common/fetch_pkg.sv
common/bht_if.sv
bpred/bht.sv
logic/instr_scan.sv
logic/instr_queue.sv
logic/pc_gen.sv
logic/fetch_frontend.sv
dv/tb_fetch_frontend.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_fetch_frontend
RTL_TOP   := fetch_frontend
FILELIST  := src.f
VFLAGS    := --binary --timescale 1ns/100ps -j 0
LINTFLAGS := --lint-only --timing --timescale 1ns/100ps -Wall
PASS_MSG  := No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf obj_dir
